// ==== common/ddr3_lite_pkg.sv ====
package ddr3_lite_pkg;

  // Word address split, bank on top, then row, then column
  localparam int BANK_BITS = 3;
  localparam int ROW_BITS  = 13;
  localparam int COL_BITS  = 7;   // Word index within the row
  localparam int ADDR_BITS = BANK_BITS + ROW_BITS + COL_BITS;
  localparam int DATA_BITS = 32;
  localparam int NUM_BANKS = 1 << BANK_BITS;

  // DRAM timing in controller clocks
  localparam int T_RCD      = 2;
  localparam int T_RP       = 2;
  localparam int RD_LATENCY = 3;  // Read strobe to returned data

  // Power-up sequence
  localparam int INIT_RST_CYCLES = 16;
  localparam int INIT_CKE_CYCLES = 8;

  // Frame opcodes and response bytes
  localparam logic [7:0] OP_WRITE = 8'h01;
  localparam logic [7:0] OP_READ  = 8'h02;
  localparam logic [7:0] ACK_BYTE = 8'h00;
  localparam logic [7:0] ERR_BYTE = 8'hEE;

  // {ras_n, cas_n, we_n} for the commands the scheduler uses
  localparam logic [2:0] CMD_NOP = 3'b111;
  localparam logic [2:0] CMD_ACT = 3'b011;
  localparam logic [2:0] CMD_RD  = 3'b101;
  localparam logic [2:0] CMD_WR  = 3'b100;
  localparam logic [2:0] CMD_PRE = 3'b010;

  typedef enum logic [1:0] {
    REQ_WRITE,
    REQ_READ,
    REQ_BAD
  } req_op_e;

  typedef struct packed {
    req_op_e              op;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    req_op_e              op;
    logic [DATA_BITS-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                 cs_n;
    logic                 ras_n;
    logic                 cas_n;
    logic                 we_n;
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  addr;  // Row for ACT, column for RD and WR
  } dfi_cmd_t;

endpackage

// ==== memreq/cmd_parser.sv ====
`timescale 1ns/1ps
module cmd_parser import ddr3_lite_pkg::*; (
  input  logic       clock,
  input  logic       rst_n_i,

  input  logic       s_tvalid_i,
  output logic       s_tready_o,
  input  logic       s_tkeep_i,
  input  logic       s_tlast_i,
  input  logic [7:0] s_tdata_i,

  output logic       req_valid_o,
  input  logic       req_ready_i,
  output mem_req_t   req_o
);

  logic                 take, beat;
  logic [3:0]           cnt_q, cnt_d;     // Kept bytes so far, saturates
  logic [3:0]           exp_len;
  logic                 frame_bad;
  req_op_e              op_q, op_dec;
  logic [23:0]          addr_q, addr_d;   // Three address bytes, MSB first
  logic [DATA_BITS-1:0] wdata_q, wdata_d;

  // One request in flight, stall the stream until it is taken
  assign s_tready_o = !req_valid_o;
  assign take       = s_tvalid_i && s_tready_o;
  assign beat       = take && s_tkeep_i;   // Filler bytes do not count

  assign op_dec = (s_tdata_i == OP_WRITE) ? REQ_WRITE :
                  (s_tdata_i == OP_READ)  ? REQ_READ  : REQ_BAD;

  assign exp_len   = (op_q == REQ_WRITE) ? 4'd8 : 4'd4;
  assign frame_bad = (op_q == REQ_BAD) || (cnt_d != exp_len);

  always_comb begin
    cnt_d   = cnt_q;
    addr_d  = addr_q;
    wdata_d = wdata_q;
    if (beat && cnt_q != 4'hF) cnt_d = cnt_q + 4'd1;
    if (beat && cnt_q >= 4'd1 && cnt_q <= 4'd3) begin
      addr_d = {addr_q[15:0], s_tdata_i};
    end
    // Data arrives LSB first, shift in from the top
    if (beat && cnt_q >= 4'd4 && cnt_q <= 4'd7) begin
      wdata_d = {s_tdata_i, wdata_q[DATA_BITS-1:8]};
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q       <= 4'd0;
      op_q        <= REQ_BAD;
      req_valid_o <= 1'b0;
    end else begin
      if (req_valid_o && req_ready_i) req_valid_o <= 1'b0;
      if (take) begin
        if (s_tlast_i) begin
          cnt_q       <= 4'd0;
          req_valid_o <= 1'b1;
        end else begin
          cnt_q <= cnt_d;
        end
        if (beat && cnt_q == 4'd0) op_q <= op_dec;
      end
    end
  end

  always_ff @(posedge clock) begin
    addr_q  <= addr_d;
    wdata_q <= wdata_d;
    if (take && s_tlast_i) begin
      req_o.op    <= frame_bad ? REQ_BAD : op_q;
      req_o.addr  <= addr_d[ADDR_BITS-1:0];
      req_o.wdata <= wdata_d;
    end
  end

  // Request must hold until the scheduler takes it
  a_req_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
    req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o));

endmodule

// ==== memreq/resp_framer.sv ====
`timescale 1ns/1ps
module resp_framer import ddr3_lite_pkg::*; (
  input  logic       clock,
  input  logic       rst_n_i,

  input  logic       rsp_valid_i,
  output logic       rsp_ready_o,
  input  mem_rsp_t   rsp_i,

  output logic       m_tvalid_o,
  input  logic       m_tready_i,
  output logic       m_tkeep_o,
  output logic       m_tlast_o,
  output logic [7:0] m_tdata_o
);

  logic                 accept, xfer;
  logic [1:0]           left_q;   // Bytes still to send after the current one
  logic [DATA_BITS-1:0] shift_q;

  assign rsp_ready_o = !m_tvalid_o;
  assign accept      = rsp_valid_i && rsp_ready_o;
  assign xfer        = m_tvalid_o && m_tready_i;

  assign m_tkeep_o = 1'b1;
  assign m_tdata_o = shift_q[7:0];
  assign m_tlast_o = (left_q == 2'd0);

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      m_tvalid_o <= 1'b0;
      left_q     <= 2'd0;
    end else if (accept) begin
      m_tvalid_o <= 1'b1;
      left_q     <= (rsp_i.op == REQ_READ) ? 2'd3 : 2'd0;
    end else if (xfer) begin
      if (left_q == 2'd0) m_tvalid_o <= 1'b0;
      else                left_q     <= left_q - 2'd1;
    end
  end

  // Read data goes out LSB first, other responses are a single byte
  always_ff @(posedge clock) begin
    if (accept) begin
      if (rsp_i.op == REQ_READ) begin
        shift_q <= rsp_i.rdata;
      end else begin
        shift_q <= {{(DATA_BITS-8){1'b0}}, (rsp_i.op == REQ_WRITE) ? ACK_BYTE : ERR_BYTE};
      end
    end else if (xfer) begin
      shift_q <= shift_q >> 8;
    end
  end

endmodule

// ==== ddr_ctrl/ddr_init.sv ====
`timescale 1ns/1ps
module ddr_init import ddr3_lite_pkg::*; (
  input  logic clock,
  input  logic rst_n_i,

  output logic dfi_rst_n_o,
  output logic dfi_cke_o,
  output logic init_done_o
);

  typedef enum logic [1:0] {
    INIT_RST,   // DRAM reset held low
    INIT_CKE,   // CKE high, waiting to settle
    INIT_DONE
  } init_st_e;

  init_st_e   st_q;
  logic [4:0] cnt_q;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      st_q  <= INIT_RST;
      cnt_q <= 5'(INIT_RST_CYCLES - 1);
    end else begin
      case (st_q)
        INIT_RST: begin
          if (cnt_q == 5'd0) begin
            st_q  <= INIT_CKE;
            cnt_q <= 5'(INIT_CKE_CYCLES - 1);
          end else begin
            cnt_q <= cnt_q - 5'd1;
          end
        end
        INIT_CKE: begin
          if (cnt_q == 5'd0) st_q  <= INIT_DONE;
          else               cnt_q <= cnt_q - 5'd1;
        end
        default: st_q <= INIT_DONE;   // Stays here until reset
      endcase
    end
  end

  assign dfi_rst_n_o = (st_q != INIT_RST);
  assign dfi_cke_o   = (st_q != INIT_RST);
  assign init_done_o = (st_q == INIT_DONE);

  // Configured only after CKE has been up for the full settle time
  a_cke_before_done: assert property (@(posedge clock) disable iff (!rst_n_i)
    init_done_o |-> dfi_cke_o && $past(dfi_cke_o, INIT_CKE_CYCLES));

endmodule

// ==== ddr_ctrl/ddr_sched.sv ====
`timescale 1ns/1ps
module ddr_sched import ddr3_lite_pkg::*; (
  input  logic                 clock,
  input  logic                 rst_n_i,
  input  logic                 init_done_i,

  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  mem_req_t             req_i,

  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output mem_rsp_t             rsp_o,

  output dfi_cmd_t             dfi_cmd_o,
  output logic                 dfi_wren_o,
  output logic [DATA_BITS-1:0] dfi_wdata_o,
  output logic                 dfi_rden_o,
  input  logic                 dfi_rvld_i,
  input  logic [DATA_BITS-1:0] dfi_rdata_i
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_PRE,
    S_TRP,
    S_ACT,
    S_TRCD,
    S_ACCESS,
    S_RDWAIT,
    S_RSP
  } sched_st_e;

  sched_st_e            st_q;
  mem_req_t             req_q;
  logic [1:0]           wait_q;
  logic [NUM_BANKS-1:0] open_vld_q;
  logic [ROW_BITS-1:0]  open_row_q [NUM_BANKS];

  logic                 accept, row_hit;
  logic [BANK_BITS-1:0] in_bank, bank_q;
  logic [ROW_BITS-1:0]  in_row, row_q;
  logic [COL_BITS-1:0]  col_q;

  assign {in_bank, in_row}      = req_i.addr[ADDR_BITS-1:COL_BITS];
  assign {bank_q, row_q, col_q} = req_q.addr;

  assign req_ready_o = init_done_i && (st_q == S_IDLE);
  assign accept      = req_valid_i && req_ready_o;
  assign row_hit     = open_vld_q[in_bank] && (open_row_q[in_bank] == in_row);
  assign rsp_valid_o = (st_q == S_RSP);
  assign dfi_wdata_o = req_q.wdata;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      st_q       <= S_IDLE;
      wait_q     <= 2'd0;
      open_vld_q <= '0;
    end else begin
      case (st_q)
        S_IDLE: begin
          if (accept) begin
            if (req_i.op == REQ_BAD)         st_q <= S_RSP;    // No DRAM access
            else if (row_hit)                st_q <= S_ACCESS;
            else if (open_vld_q[in_bank])    st_q <= S_PRE;    // Wrong row open
            else                             st_q <= S_ACT;
          end
        end
        S_PRE: begin
          open_vld_q[bank_q] <= 1'b0;
          wait_q             <= 2'(T_RP - 1);
          st_q               <= S_TRP;
        end
        S_TRP: begin
          if (wait_q == 2'd0) st_q   <= S_ACT;
          else                wait_q <= wait_q - 2'd1;
        end
        S_ACT: begin
          open_vld_q[bank_q] <= 1'b1;
          wait_q             <= 2'(T_RCD - 1);
          st_q               <= S_TRCD;
        end
        S_TRCD: begin
          if (wait_q == 2'd0) st_q   <= S_ACCESS;
          else                wait_q <= wait_q - 2'd1;
        end
        S_ACCESS: st_q <= (req_q.op == REQ_READ) ? S_RDWAIT : S_RSP;
        S_RDWAIT: if (dfi_rvld_i) st_q <= S_RSP;
        S_RSP:    if (rsp_ready_i) st_q <= S_IDLE;
        default:  st_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_q    <= req_i;
      rsp_o.op <= req_i.op;
    end
    if (st_q == S_ACT) open_row_q[bank_q] <= row_q;
    if (st_q == S_RDWAIT && dfi_rvld_i) rsp_o.rdata <= dfi_rdata_i;
  end

  // Command decode, NOP unless the state issues something
  always_comb begin
    dfi_cmd_o.cs_n = 1'b1;
    {dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n} = CMD_NOP;
    dfi_cmd_o.bank = bank_q;
    dfi_cmd_o.addr = row_q;
    dfi_wren_o     = 1'b0;
    dfi_rden_o     = 1'b0;
    case (st_q)
      S_PRE: begin
        dfi_cmd_o.cs_n = 1'b0;
        {dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n} = CMD_PRE;
      end
      S_ACT: begin
        dfi_cmd_o.cs_n = 1'b0;
        {dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n} = CMD_ACT;
      end
      S_ACCESS: begin
        dfi_cmd_o.cs_n = 1'b0;
        dfi_cmd_o.addr = {{(ROW_BITS-COL_BITS){1'b0}}, col_q};
        if (req_q.op == REQ_READ) begin
          {dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n} = CMD_RD;
          dfi_rden_o = 1'b1;
        end else begin
          {dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n} = CMD_WR;
          dfi_wren_o = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // RD or WR only to a bank whose row the table holds open
  a_access_open_bank: assert property (@(posedge clock) disable iff (!rst_n_i)
    !dfi_cmd_o.cs_n && dfi_cmd_o.ras_n && !dfi_cmd_o.cas_n |-> open_vld_q[dfi_cmd_o.bank]);

  // Read data returns a fixed number of cycles after the strobe
  a_rd_latency: assert property (@(posedge clock) disable iff (!rst_n_i)
    dfi_rden_o |-> ##RD_LATENCY dfi_rvld_i);

  a_rvld_expected: assert property (@(posedge clock) disable iff (!rst_n_i)
    dfi_rvld_i |-> $past(dfi_rden_o, RD_LATENCY));

endmodule

// ==== design/ddr3_lite_top.sv ====
`timescale 1ns/1ps
module ddr3_lite_top import ddr3_lite_pkg::*; (
  input  logic                 clock,
  input  logic                 rst_n_i,

  // From USB or SPI
  input  logic                 s_tvalid_i,
  output logic                 s_tready_o,
  input  logic                 s_tkeep_i,
  input  logic                 s_tlast_i,
  input  logic [7:0]           s_tdata_i,

  // To USB or SPI
  output logic                 m_tvalid_o,
  input  logic                 m_tready_i,
  output logic                 m_tkeep_o,
  output logic                 m_tlast_o,
  output logic [7:0]           m_tdata_o,

  // DFI-style DRAM side
  output dfi_cmd_t             dfi_cmd_o,
  output logic                 dfi_wren_o,
  output logic [DATA_BITS-1:0] dfi_wdata_o,
  output logic                 dfi_rden_o,
  input  logic                 dfi_rvld_i,
  input  logic [DATA_BITS-1:0] dfi_rdata_i,
  output logic                 dfi_rst_n_o,
  output logic                 dfi_cke_o,

  output logic                 configured_o
);

  logic     req_valid, req_ready;
  logic     rsp_valid, rsp_ready;
  mem_req_t req;
  mem_rsp_t rsp;

  cmd_parser u_parser (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .s_tvalid_i (s_tvalid_i),
    .s_tready_o (s_tready_o),
    .s_tkeep_i  (s_tkeep_i),
    .s_tlast_i  (s_tlast_i),
    .s_tdata_i  (s_tdata_i),
    .req_valid_o(req_valid),
    .req_ready_i(req_ready),
    .req_o      (req)
  );

  ddr_init u_init (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .dfi_rst_n_o(dfi_rst_n_o),
    .dfi_cke_o  (dfi_cke_o),
    .init_done_o(configured_o)   // Also gates the scheduler
  );

  ddr_sched u_sched (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .init_done_i(configured_o),
    .req_valid_i(req_valid),
    .req_ready_o(req_ready),
    .req_i      (req),
    .rsp_valid_o(rsp_valid),
    .rsp_ready_i(rsp_ready),
    .rsp_o      (rsp),
    .dfi_cmd_o  (dfi_cmd_o),
    .dfi_wren_o (dfi_wren_o),
    .dfi_wdata_o(dfi_wdata_o),
    .dfi_rden_o (dfi_rden_o),
    .dfi_rvld_i (dfi_rvld_i),
    .dfi_rdata_i(dfi_rdata_i)
  );

  resp_framer u_framer (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .rsp_valid_i(rsp_valid),
    .rsp_ready_o(rsp_ready),
    .rsp_i      (rsp),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .m_tkeep_o  (m_tkeep_o),
    .m_tlast_o  (m_tlast_o),
    .m_tdata_o  (m_tdata_o)
  );

endmodule

// ==== testbench/dram_model.sv ====
`timescale 1ns/1ps
module dram_model import ddr3_lite_pkg::*; (
  input  logic                 clock,
  input  logic                 rst_n_i,
  input  dfi_cmd_t             cmd_i,
  input  logic                 wren_i,
  input  logic [DATA_BITS-1:0] wdata_i,
  input  logic                 rden_i,
  output logic                 rvld_o,
  output logic [DATA_BITS-1:0] rdata_o,
  output int                   act_cnt_o,
  output int                   err_cnt_o
);

  logic [NUM_BANKS-1:0]  open_q;
  logic [ROW_BITS-1:0]   row_q [NUM_BANKS];
  logic [ADDR_BITS-1:0]  waddr_q [$];     // Written words, newest last
  logic [DATA_BITS-1:0]  wword_q [$];
  logic [RD_LATENCY-1:0] vld_pipe;
  logic [DATA_BITS-1:0]  data_pipe [RD_LATENCY];
  logic [ADDR_BITS-1:0]  word_addr;

  assign rvld_o    = vld_pipe[RD_LATENCY-1];
  assign rdata_o   = data_pipe[RD_LATENCY-1];
  assign word_addr = {cmd_i.bank, row_q[cmd_i.bank], cmd_i.addr[COL_BITS-1:0]};

  // Unwritten words read back as a pattern of their own address
  function automatic logic [DATA_BITS-1:0] read_word(input logic [ADDR_BITS-1:0] a);
    logic [DATA_BITS-1:0] w;
    w = {9'h1A5, a};
    foreach (waddr_q[i]) begin
      if (waddr_q[i] == a) w = wword_q[i];
    end
    return w;
  endfunction

  always @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      open_q    <= '0;
      vld_pipe  <= '0;
      act_cnt_o <= 0;
      err_cnt_o <= 0;
    end else begin
      vld_pipe     <= {vld_pipe[RD_LATENCY-2:0], rden_i};
      data_pipe[0] <= read_word(word_addr);
      for (int i = 1; i < RD_LATENCY; i++) data_pipe[i] <= data_pipe[i-1];
      if (!cmd_i.cs_n) begin
        case ({cmd_i.ras_n, cmd_i.cas_n, cmd_i.we_n})
          CMD_ACT: begin
            assert (!open_q[cmd_i.bank]) else begin
              $display("DRAM model: ACT to bank %0d while a row is still open at %0t",
                       cmd_i.bank, $time);
              err_cnt_o <= err_cnt_o + 1;
            end
            open_q[cmd_i.bank] <= 1'b1;
            row_q[cmd_i.bank]  <= cmd_i.addr;
            act_cnt_o          <= act_cnt_o + 1;
          end
          CMD_PRE: open_q[cmd_i.bank] <= 1'b0;
          CMD_RD, CMD_WR: begin
            assert (open_q[cmd_i.bank]) else begin
              $display("DRAM model: access to closed bank %0d at %0t", cmd_i.bank, $time);
              err_cnt_o <= err_cnt_o + 1;
            end
            if (wren_i) begin
              waddr_q.push_back(word_addr);
              wword_q.push_back(wdata_i);
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== testbench/tb_ddr3_lite.sv ====
`timescale 1ns/1ps
module tb_ddr3_lite import ddr3_lite_pkg::*; ();

  localparam int VEC_DEPTH = 256;
  localparam int TEST_CYCLES = 200;

  logic                 clock = 1'b0;
  logic                 rst_n_i;
  logic                 s_tvalid_i, s_tready_o, s_tkeep_i, s_tlast_i;
  logic [7:0]           s_tdata_i;
  logic                 m_tvalid_o, m_tready_i, m_tkeep_o, m_tlast_o;
  logic [7:0]           m_tdata_o;
  dfi_cmd_t             dfi_cmd;
  logic                 dfi_wren, dfi_rden, dfi_rvld, dfi_rst_n, dfi_cke, configured_o;
  logic [DATA_BITS-1:0] dfi_wdata, dfi_rdata;
  int                   dram_act, dram_err;

  logic [15:0]          vec [VEC_DEPTH];  // Kind, flags, byte
  logic [9:0]           frm_q [$];        // Keep, last, byte
  logic [8:0]           exp_q [$];        // Last, byte
  logic [NUM_BANKS-1:0] tb_open;
  logic [ROW_BITS-1:0]  tb_row [NUM_BANKS];
  logic [31:0]          rng_state = 32'h0bb1_46c8;
  logic                 pace_rnd, src_gap;
  int                   pred_act, err_cnt, tests_run, tests_failed;
  int                   cycle_cnt, timeout_cycles;

  ddr3_lite_top u_dut (
    .clock(clock), .rst_n_i(rst_n_i),
    .s_tvalid_i(s_tvalid_i), .s_tready_o(s_tready_o), .s_tkeep_i(s_tkeep_i),
    .s_tlast_i(s_tlast_i), .s_tdata_i(s_tdata_i),
    .m_tvalid_o(m_tvalid_o), .m_tready_i(m_tready_i), .m_tkeep_o(m_tkeep_o),
    .m_tlast_o(m_tlast_o), .m_tdata_o(m_tdata_o),
    .dfi_cmd_o(dfi_cmd), .dfi_wren_o(dfi_wren), .dfi_wdata_o(dfi_wdata),
    .dfi_rden_o(dfi_rden), .dfi_rvld_i(dfi_rvld), .dfi_rdata_i(dfi_rdata),
    .dfi_rst_n_o(dfi_rst_n), .dfi_cke_o(dfi_cke), .configured_o(configured_o)
  );

  dram_model u_dram (
    .clock(clock), .rst_n_i(rst_n_i), .cmd_i(dfi_cmd), .wren_i(dfi_wren),
    .wdata_i(dfi_wdata), .rden_i(dfi_rden), .rvld_o(dfi_rvld), .rdata_o(dfi_rdata),
    .act_cnt_o(dram_act), .err_cnt_o(dram_err)
  );

  always #2 clock = !clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // One draw per cycle so the source gap is ready for the driver at +1 ns
  always @(posedge clock) begin
    rng_state = xorshift32(rng_state);
    src_gap   = pace_rnd && (rng_state[1:0] == 2'd0);
    #1;
    m_tready_i = !(pace_rnd && (rng_state[5:4] == 2'd0));
  end

  always @(posedge clock) begin
    cycle_cnt++;
    if (timeout_cycles != 0 && cycle_cnt >= timeout_cycles) begin
      $display("Timeout after %0d cycles, a response never completed", cycle_cnt);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  // No DRAM command or strobe may go out before the controller is configured
  always @(negedge clock) begin
    if (configured_o !== 1'b1) begin
      check_val("dfi_cmd_o.cs_n", 1'b1, dfi_cmd.cs_n);
      check_val("dfi_wren_o", 1'b0, dfi_wren);
      check_val("dfi_rden_o", 1'b0, dfi_rden);
    end
  end

  task automatic report_test(input int id, input int err_start);
    tests_run++;
    if (err_cnt == err_start) begin
      $display("Test %0d: pass", id);
    end else begin
      tests_failed++;
      $display("Test %0d: fail with %0d errors", id, err_cnt - err_start);
    end
  endtask

  task automatic run_init_test();
    int cyc;
    cyc = 0;
    @(negedge clock);
    check_val("s_tready_o", 1'b1, s_tready_o);
    check_val("m_tvalid_o", 1'b0, m_tvalid_o);
    check_val("configured_o", 1'b0, configured_o);
    while (!configured_o) begin
      @(posedge clock);
      cyc++;
      @(negedge clock);
      if (!configured_o) begin
        check_val("dfi_cke_o", cyc >= INIT_RST_CYCLES, dfi_cke);
        check_val("dfi_rst_n_o", cyc >= INIT_RST_CYCLES, dfi_rst_n);
      end
    end
    check_val("init cycles", INIT_RST_CYCLES + INIT_CKE_CYCLES, cyc);
  endtask

  // Own copy of the open row per bank to count the ACTs each block must cause
  task automatic predict_acts();
    logic [7:0]           kb [16];
    int                   n;
    logic [23:0]          a;
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0]  row;
    n = 0;
    foreach (frm_q[i]) begin
      if (frm_q[i][9] && n < 16) begin
        kb[n] = frm_q[i][7:0];
        n++;
      end
      if (frm_q[i][8]) begin
        if ((kb[0] == OP_WRITE && n == 8) || (kb[0] == OP_READ && n == 4)) begin
          a    = {kb[1], kb[2], kb[3]};
          bank = a[ADDR_BITS-1 -: BANK_BITS];
          row  = a[COL_BITS +: ROW_BITS];
          if (!(tb_open[bank] && tb_row[bank] == row)) begin
            pred_act++;
            tb_open[bank] = 1'b1;
            tb_row[bank]  = row;
          end
        end
        n = 0;
      end
    end
  endtask

  task automatic send_frames();
    int i;
    i = 0;
    while (i < frm_q.size()) begin
      @(posedge clock);
      #1;
      s_tvalid_i = !src_gap;
      {s_tkeep_i, s_tlast_i, s_tdata_i} = frm_q[i];
      @(negedge clock);
      if (s_tvalid_i && s_tready_o) i++;
    end
    @(posedge clock);
    #1;
    s_tvalid_i = 1'b0;
  endtask

  task automatic collect_response();
    int i;
    i = 0;
    while (i < exp_q.size()) begin
      @(negedge clock);
      if (m_tvalid_o && m_tready_i) begin
        check_val("m_tdata_o", exp_q[i][7:0], m_tdata_o);
        check_val("m_tlast_o", exp_q[i][8], m_tlast_o);
        check_val("m_tkeep_o", 1'b1, m_tkeep_o);
        i++;
      end
    end
  endtask

  initial begin
    int p, n_blocks, err_start, err_seen;
    rst_n_i    = 1'b0;
    s_tvalid_i = 1'b0;
    s_tkeep_i  = 1'b0;
    s_tlast_i  = 1'b0;
    s_tdata_i  = 8'h00;
    m_tready_i = 1'b1;
    pace_rnd   = 1'b0;
    src_gap    = 1'b0;
    tb_open    = '0;
    pred_act   = 0;
    err_seen   = 0;
    n_blocks   = 0;
    for (int i = 0; i < VEC_DEPTH; i++) vec[i] = '0;
    $readmemh("testbench/golden_vectors.txt", vec);
    for (int i = 0; i < VEC_DEPTH; i++) begin
      if (vec[i][15:12] == 4'h3) n_blocks++;
    end
    timeout_cycles = (n_blocks + 1) * TEST_CYCLES + 16 + INIT_RST_CYCLES + INIT_CKE_CYCLES;
    if (n_blocks == 0) begin
      $display("Golden vector file is missing or holds no test");
      err_cnt++;
    end

    repeat (16) @(posedge clock);
    #1;
    rst_n_i = 1'b1;

    err_start = err_cnt;
    p = 0;
    while (p < VEC_DEPTH && vec[p][15:12] != 4'h0) begin
      frm_q.delete();
      exp_q.delete();
      while (p < VEC_DEPTH - 1 && vec[p][15:12] != 4'h3) begin
        if (vec[p][15:12] == 4'h1) frm_q.push_back(vec[p][9:0]);
        else if (vec[p][15:12] == 4'h2) exp_q.push_back(vec[p][8:0]);
        p++;
      end
      pace_rnd = vec[p][8];
      predict_acts();
      if (tests_run == 0) begin
        // First frames arrive during power-up and must wait for configured_o
        fork
          begin
            run_init_test();
            report_test(1, err_start);
            err_start = err_cnt;
          end
          send_frames();
          collect_response();
        join
      end else begin
        err_start = err_cnt;
        fork
          send_frames();
          collect_response();
        join
      end
      check_val("dram act count", pred_act, dram_act);
      assert (dram_err == err_seen) else begin
        $display("DRAM model saw a command order error during test %0d", vec[p][7:0]);
        err_cnt++;
        err_seen = dram_err;
      end
      report_test(vec[p][7:0], err_start);
      pace_rnd = 1'b0;
      p++;
    end

    $display("Tests run %0d, failed %0d, failed checks %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/golden_vectors.txt ====
// Word: kind, flags, byte. Kind 1 frame byte (flag 2 keep, 1 tlast),
// kind 2 expected response byte (flag 1 tlast), kind 3 end of test (flag 1 random pacing, byte id)
// Test 2: write 0x100283 then read it back
1201 1210 1202 1283 12EF 12BE 12AD 13DE 1202 1210 1202 1383
2100 20EF 20BE 20AD 21DE 3002
// Test 3: row hit in bank 1, row 5
1201 1210 1202 1289 1278 1256 1234 1312 1202 1210 1202 1389
2100 2078 2056 2034 2112 3003
// Test 4: row miss in bank 1, row 9 then row 5 then row 9
1201 1210 1204 1280 1201 1200 12FE 13CA 1202 1210 1202 1383 1202 1210 1204 1380
2100 20EF 20BE 20AD 21DE 2001 2000 20FE 21CA 3004
// Test 5: unknown opcode, then a good read
1207 1200 1200 1301 1202 1210 1202 1383
21EE 20EF 20BE 20AD 21DE 3005
// Test 6: short write, read with a late tlast, then a good read
1201 1210 1202 1283 1211 1222 1333 1202 1210 1202 1283 1399 1202 1210 1202 1383
21EE 21EE 20EF 20BE 20AD 21DE 3006
// Test 7: write with keep-low filler bytes, then read 0x200005
1201 105A 1220 1200 1205 1244 10A5 1233 1222 1311 1202 1220 1200 1305
2100 2044 2033 2022 2111 3007
// Test 8: back-pressure on both streams, bank 3 rows 0 and 1
1201 1230 1200 1210 12D4 12C3 12B2 13A1 1201 1230 1200 1211 1204 1203 1202 1301
1202 1230 1200 1310 1202 1230 1200 1311 1201 1230 1200 1280 12AA 1255 12AA 1355
1202 1230 1200 1310 1202 1230 1200 1380
2100 2100 20D4 20C3 20B2 21A1 2004 2003 2002 2101 2100 20D4 20C3 20B2 21A1
20AA 2055 20AA 2155 3108
0000

// ==== all.f ====
common/ddr3_lite_pkg.sv
memreq/cmd_parser.sv
memreq/resp_framer.sv
ddr_ctrl/ddr_init.sv
ddr_ctrl/ddr_sched.sv
design/ddr3_lite_top.sv
testbench/dram_model.sv
testbench/tb_ddr3_lite.sv

// ==== Bender.yml ====
package:
  name: ddr3_lite

sources:
  - files:
      - common/ddr3_lite_pkg.sv
      - memreq/cmd_parser.sv
      - memreq/resp_framer.sv
      - ddr_ctrl/ddr_init.sv
      - ddr_ctrl/ddr_sched.sv
      - design/ddr3_lite_top.sv
  - target: test
    files:
      - testbench/dram_model.sv
      - testbench/tb_ddr3_lite.sv
